//--- fetch_trace.txt
# Columns op a b c in hex with L addr word and T pc target kind (0 branch 1 call 2 return)
# R redirect_pc and S stall_cycles and E pc instr with unused columns set to 0
L 00000000 00100093 0
L 00000004 00200113 0
L 00000008 0180006f 0
L 00000010 00628313 0
L 00000020 00308193 0
L 00000024 01c000ef 0
L 00000028 00418213 0
L 00000040 00510293 0
L 00000044 00008067 0
T 00000008 00000020 0
T 00000024 00000040 1
T 00000044 00000000 2
E 00000000 00100093 0
E 00000004 00200113 0
S 00000005 0 0
E 00000008 0180006f 0
E 00000020 00308193 0
E 00000024 01c000ef 0
E 00000040 00510293 0
E 00000044 00008067 0
E 00000028 00418213 0
R 00000010 0 0
E 00000010 00628313 0

//--- verilog.f
fetch_pkg.sv
pred_if.sv
branch_target_buffer.sv
return_stack.sv
pc_gen.sv
instr_bram.sv
fetch_stage_bram.sv
fetch_top.sv
fetch_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -f verilog.f --top-module fetch_tb -o fetch_sim &&
./obj_dir/fetch_sim | tee /dev/stderr | grep -F "Test passed" > /dev/null &&
exit 0 || exit 1

//--- fetch_tb.sv
`timescale 1ns/1ps

// Trace-driven testbench for the fetch front end
// Loads and training run first with decode held off, then fetch is let go
// and every slot taken by decode is checked against the next expect record
module fetch_tb;

  logic                       clk;
  logic                       rst_n;
  logic                       id_ready;
  logic                       redirect_valid;
  logic [fetch_pkg::xlen-1:0] redirect_pc;
  logic                       upd_valid;
  logic [fetch_pkg::xlen-1:0] upd_pc;
  logic [fetch_pkg::xlen-1:0] upd_target;
  fetch_pkg::btb_kind_e       upd_kind;
  logic                       wb_cyc;
  logic                       wb_stb;
  logic                       wb_we;
  logic [fetch_pkg::xlen-1:0] wb_adr;
  logic [31:0]                wb_dat_w;
  logic                       wb_ack;
  logic [31:0]                instr_id;
  logic [fetch_pkg::xlen-1:0] pc_id;
  logic [fetch_pkg::xlen-1:0] pc_plus4_id;
  logic                       valid_id;
  logic                       btb_hit_id;
  logic                       btb_taken_id;
  logic                       btb_is_return_id;
  logic [fetch_pkg::xlen-1:0] btb_target_id;
  logic [2:0]                 pred_flags;

  // Trace records with one entry per line of the trace file
  string                      rec_op [$];
  logic [31:0]                rec_a [$];
  logic [31:0]                rec_b [$];
  logic [31:0]                rec_c [$];

  // Reference model of the trained entries and of the return stack
  fetch_pkg::btb_kind_e       model_kind [logic [31:0]];
  logic [31:0]                model_target [logic [31:0]];
  logic [31:0]                model_ras [$];

  integer                     seed;
  int                         errors = 0;
  int                         checks = 0;
  int                         tests = 0;
  int                         cycles = 0;
  int                         cycle_limit = 100;

  assign pred_flags = {btb_hit_id, btb_taken_id, btb_is_return_id};

  fetch_top dut0 (.*);

  always #4 clk = ~clk;

  // The watchdog limit is set once the trace length is known
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout after %0d cycles while the trace was still running", cycles);
      $display("Test failed");
      $finish;
    end
  end

  task automatic check_addr(input logic [fetch_pkg::xlen-1:0] got,
                            input logic [fetch_pkg::xlen-1:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_word(input logic [31:0] got, input logic [31:0] exp,
                            input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flags(input logic [2:0] got, input logic [2:0] exp,
                             input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s hit/taken/ret are %b, expected %b",
               $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // Hit, taken and return flags that a trained entry of this kind produces
  // A return counts as taken only when the stack can supply its target
  function automatic logic [2:0] expected_flags(input fetch_pkg::btb_kind_e kind,
                                                input logic ret_ok);
    return {1'b1, (kind != fetch_pkg::btb_return) || ret_ok,
            kind == fetch_pkg::btb_return};
  endfunction

  // Reads every record up front so the watchdog limit can follow its length
  task automatic read_trace(input int fd);
    string       op;
    string       rest;
    int          code;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    while (!$feof(fd)) begin
      code = $fscanf(fd, "%s", op);
      if (code != 1) begin
        break;
      end
      if (op == "#") begin
        code = $fgets(rest, fd);
      end else begin
        code = $fscanf(fd, "%h %h %h", a, b, c);
        rec_op.push_back(op);
        rec_a.push_back(a);
        rec_b.push_back(b);
        rec_c.push_back(c);
      end
    end
  endtask

  // One Wishbone classic write, held until the slave acknowledges
  task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
    int waits;
    waits = 0;
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= 1'b1;
    wb_adr   <= addr;
    wb_dat_w <= data;
    @(negedge clk);
    while (!wb_ack) begin
      waits++;
      @(negedge clk);
    end
    // The ack belongs in the cycle right after the request cycle
    check_bit(waits == 1, 1'b1, "wb_ack in the cycle after the request");
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
    @(negedge clk);
    check_bit(wb_ack, 1'b0, "wb_ack one cycle later");
  endtask

  task automatic train_entry(input logic [31:0] pc, input logic [31:0] target,
                             input fetch_pkg::btb_kind_e kind);
    @(posedge clk);
    upd_valid  <= 1'b1;
    upd_pc     <= pc;
    upd_target <= target;
    upd_kind   <= kind;
    @(posedge clk);
    upd_valid <= 1'b0;
    model_kind[pc]   = kind;
    model_target[pc] = target;
  endtask

  // Waits under random back-pressure for the next slot decode takes
  task automatic expect_slot(input logic [31:0] pc, input logic [31:0] instr);
    logic                 hit;
    logic                 ret_ok;
    logic [2:0]           flags;
    logic [31:0]          target;
    fetch_pkg::btb_kind_e kind;
    hit    = model_kind.exists(pc);
    kind   = fetch_pkg::btb_branch;
    target = '0;
    if (hit) begin
      kind   = model_kind[pc];
      target = model_target[pc];
    end
    ret_ok = hit && (kind == fetch_pkg::btb_return) && (model_ras.size() != 0);
    if (ret_ok) begin
      target = model_ras[$];
    end
    flags = hit ? expected_flags(kind, ret_ok) : 3'b000;
    do begin
      @(posedge clk);
      id_ready <= (($random(seed) & 3) != 0);
      @(negedge clk);
    end while (!(valid_id && id_ready));
    check_addr(pc_id, pc, "pc_id");
    check_addr(pc_plus4_id, pc + 32'd4, "pc_plus4_id");
    check_word(instr_id, instr, "instr_id");
    check_flags(pred_flags, flags, "prediction");
    if (hit) begin
      check_addr(btb_target_id, target, "btb_target_id");
    end
    // The stack moves when the predicted call or return is taken
    if (hit && (kind == fetch_pkg::btb_call)) begin
      model_ras.push_back(pc + 32'd4);
    end
    if (ret_ok) begin
      void'(model_ras.pop_back());
    end
  endtask

  // While decode is held off the slot on the outputs must not change
  task automatic hold_stall(input int n);
    logic [31:0] held_pc;
    logic [31:0] held_instr;
    logic        held_valid;
    @(posedge clk);
    id_ready <= 1'b0;
    @(negedge clk);
    held_pc    = pc_id;
    held_instr = instr_id;
    held_valid = valid_id;
    repeat (n - 1) begin
      @(negedge clk);
      check_addr(pc_id, held_pc, "pc_id held in stall");
      check_word(instr_id, held_instr, "instr_id held in stall");
      check_bit(valid_id, held_valid, "valid_id held in stall");
    end
  endtask

  // One redirect cycle leaves exactly one flushed NOP slot behind
  task automatic redirect_to(input logic [31:0] target);
    @(posedge clk);
    redirect_valid <= 1'b1;
    redirect_pc    <= target;
    id_ready       <= (($random(seed) & 3) != 0);
    @(posedge clk);
    redirect_valid <= 1'b0;
    id_ready       <= (($random(seed) & 3) != 0);
    @(negedge clk);
    check_bit(valid_id, 1'b0, "valid_id after redirect");
    check_word(instr_id, fetch_pkg::i_nop, "instr_id after redirect");
  endtask

  task automatic run_record(input int idx);
    int    err_before;
    string name;
    err_before = errors;
    name = rec_op[idx];
    if (rec_op[idx] == "L") begin
      write_word(rec_a[idx], rec_b[idx]);
    end else if (rec_op[idx] == "T") begin
      train_entry(rec_a[idx], rec_b[idx], fetch_pkg::btb_kind_e'(rec_c[idx][1:0]));
    end else if (rec_op[idx] == "E") begin
      expect_slot(rec_a[idx], rec_b[idx]);
    end else if (rec_op[idx] == "S") begin
      hold_stall(int'(rec_a[idx]));
    end else if (rec_op[idx] == "R") begin
      redirect_to(rec_a[idx]);
    end else begin
      errors++;
      $display("Trace record %0d has the unknown op %s", idx, rec_op[idx]);
    end
    tests++;
    $display("record %0d %s %h: %s", idx, name, rec_a[idx],
             (errors == err_before) ? "ok" : "mismatch");
  endtask

  initial begin
    int fd;
    clk            = 1'b0;
    rst_n          = 1'b0;
    id_ready       = 1'b0;
    redirect_valid = 1'b0;
    redirect_pc    = '0;
    upd_valid      = 1'b0;
    upd_pc         = '0;
    upd_target     = '0;
    upd_kind       = fetch_pkg::btb_branch;
    wb_cyc         = 1'b0;
    wb_stb         = 1'b0;
    wb_we          = 1'b0;
    wb_adr         = '0;
    wb_dat_w       = '0;
    seed           = 52646;
    fd = $fopen("fetch_trace.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("The trace file fetch_trace.txt could not be opened");
    end else begin
      read_trace(fd);
      $fclose(fd);
    end
    cycle_limit = 40 * rec_op.size() + 100;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_bit(valid_id, 1'b0, "valid_id after reset");
    check_bit(wb_ack, 1'b0, "wb_ack after reset");
    check_flags(pred_flags, 3'b000, "prediction after reset");
    for (int i = 0; i < rec_op.size(); i++) begin
      run_record(i);
    end
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- fetch_top.sv
`timescale 1ns/1ps

// Fetch front end top level
// Redirects and buffer training come from the rest of the core
module fetch_top (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       id_ready,
  input  logic                       redirect_valid,
  input  logic [fetch_pkg::xlen-1:0] redirect_pc,
  input  logic                       upd_valid,
  input  logic [fetch_pkg::xlen-1:0] upd_pc,
  input  logic [fetch_pkg::xlen-1:0] upd_target,
  input  fetch_pkg::btb_kind_e       upd_kind,
  input  logic                       wb_cyc,
  input  logic                       wb_stb,
  input  logic                       wb_we,
  input  logic [fetch_pkg::xlen-1:0] wb_adr,
  input  logic [31:0]                wb_dat_w,
  output logic                       wb_ack,
  output logic [31:0]                instr_id,
  output logic [fetch_pkg::xlen-1:0] pc_id,
  output logic [fetch_pkg::xlen-1:0] pc_plus4_id,
  output logic                       valid_id,
  output logic                       btb_hit_id,
  output logic                       btb_taken_id,
  output logic                       btb_is_return_id,
  output logic [fetch_pkg::xlen-1:0] btb_target_id
);

  logic                       stall;
  logic                       accept;
  logic [fetch_pkg::xlen-1:0] pc;
  logic [fetch_pkg::xlen-1:0] next_pc;
  logic                       ras_push;
  logic                       ras_pop;
  logic [fetch_pkg::xlen-1:0] ras_push_addr;
  logic                       imem_arvalid;
  logic [fetch_pkg::xlen-1:0] imem_araddr;
  logic [31:0]                imem_rdata;

  // Buffer and stack each drive part of a bundle, merged into pred_bus
  pred_if pred_bus ();
  pred_if ras_bus ();

  assign pred_bus.ras_valid  = ras_bus.ras_valid;
  assign pred_bus.ras_target = ras_bus.ras_target;

  // The PC advances on its own prediction only when not stalled or redirected
  assign stall         = !id_ready;
  assign accept        = id_ready && !redirect_valid;
  assign ras_push_addr = pc + 32'd4;

  branch_target_buffer btb0 (
    .clk(clk), .rst_n(rst_n), .lookup_pc(next_pc), .accept(accept),
    .upd_valid(upd_valid), .upd_pc(upd_pc), .upd_target(upd_target),
    .upd_kind(upd_kind), .pred(pred_bus.source), .push(ras_push), .pop(ras_pop)
  );

  return_stack ras0 (
    .clk(clk), .rst_n(rst_n), .push(ras_push), .pop(ras_pop),
    .push_addr(ras_push_addr), .pred(ras_bus.source)
  );

  pc_gen pcg0 (
    .clk(clk), .rst_n(rst_n), .stall(stall), .redirect_valid(redirect_valid),
    .redirect_pc(redirect_pc), .pred(pred_bus.sink), .pc(pc), .next_pc(next_pc)
  );

  instr_bram imem0 (
    .clk(clk), .rst_n(rst_n), .arvalid(imem_arvalid), .araddr(imem_araddr),
    .rdata(imem_rdata), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
    .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_ack(wb_ack)
  );

  fetch_stage_bram if0 (
    .clk(clk), .rst_n(rst_n), .pc(pc), .pc_next(next_pc), .pc_stall(stall),
    .if_id_flush(redirect_valid), .m_ready(id_ready), .pred(pred_bus.sink),
    .imem_arvalid(imem_arvalid), .imem_araddr(imem_araddr), .imem_rdata(imem_rdata),
    .instr_id(instr_id), .pc_id(pc_id), .pc_plus4_id(pc_plus4_id),
    .btb_hit_id(btb_hit_id), .btb_taken_id(btb_taken_id),
    .btb_is_return_id(btb_is_return_id), .btb_target_id(btb_target_id),
    .valid_id(valid_id)
  );

endmodule

//--- fetch_stage_bram.sv
`timescale 1ns/1ps

// Fetch stage for a block RAM with one cycle of read latency
// The memory is addressed early with pc_next, so the word on imem_rdata
// always belongs to pc, and pc with its prediction is buffered next to it
module fetch_stage_bram (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [fetch_pkg::xlen-1:0] pc,
  input  logic [fetch_pkg::xlen-1:0] pc_next,
  input  logic                       pc_stall,
  input  logic                       if_id_flush,
  input  logic                       m_ready,
  pred_if.sink                       pred,
  output logic                       imem_arvalid,
  output logic [fetch_pkg::xlen-1:0] imem_araddr,
  input  logic [31:0]                imem_rdata,
  output logic [31:0]                instr_id,
  output logic [fetch_pkg::xlen-1:0] pc_id,
  output logic [fetch_pkg::xlen-1:0] pc_plus4_id,
  output logic                       btb_hit_id,
  output logic                       btb_taken_id,
  output logic                       btb_is_return_id,
  output logic [fetch_pkg::xlen-1:0] btb_target_id,
  output logic                       valid_id
);

  logic [fetch_pkg::xlen-1:0] pc_buf;
  logic [fetch_pkg::xlen-1:0] pc_plus4_buf;
  logic [fetch_pkg::xlen-1:0] tgt_buf;
  logic                       hit_buf;
  logic                       taken_buf;
  logic                       is_return_buf;
  logic [31:0]                instr_buf;
  logic                       valid_buf;
  logic                       started;
  logic                       ret_used;
  logic [fetch_pkg::xlen-1:0] pred_tgt;

  // Early fetch with the next address
  // A redirect still reads its target while the consumer is stalled
  assign imem_araddr  = pc_next;
  assign imem_arvalid = !pc_stall || if_id_flush;

  // A return steers fetch only when the stack has an entry
  // Decode sees the target that fetch actually followed
  assign ret_used = pred.hit && pred.is_return && pred.ras_valid;
  assign pred_tgt = ret_used ? pred.ras_target : pred.target;

  // Prediction flags of the slot handed to decode
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      hit_buf       <= 1'b0;
      taken_buf     <= 1'b0;
      is_return_buf <= 1'b0;
    end else if (m_ready) begin
      hit_buf       <= pred.hit;
      taken_buf     <= pred.taken || ret_used;
      is_return_buf <= pred.is_return;
    end
  end

  // PC and target follow the slot even when it is flushed
  always_ff @(posedge clk) begin
    if (m_ready) begin
      pc_buf       <= pc;
      pc_plus4_buf <= pc + 32'd4;
      tgt_buf      <= pred_tgt;
    end
  end

  // Flushed and reset slots carry a NOP
  // A flush wins over a stall
  always_ff @(posedge clk) begin
    if (!rst_n || if_id_flush) begin
      instr_buf <= fetch_pkg::i_nop;
    end else if (m_ready) begin
      instr_buf <= imem_rdata;
    end
  end

  // The first accepted cycle after reset still holds the stale read,
  // so validity waits for started
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      started   <= 1'b0;
      valid_buf <= 1'b0;
    end else begin
      if (m_ready) begin
        started <= 1'b1;
      end
      if (if_id_flush) begin
        valid_buf <= 1'b0;
      end else if (m_ready) begin
        valid_buf <= started;
      end
    end
  end

  assign instr_id         = instr_buf;
  assign pc_id            = pc_buf;
  assign pc_plus4_id      = pc_plus4_buf;
  assign btb_hit_id       = hit_buf;
  assign btb_taken_id     = taken_buf;
  assign btb_is_return_id = is_return_buf;
  assign btb_target_id    = tgt_buf;
  assign valid_id         = valid_buf;

endmodule

//--- instr_bram.sv
`timescale 1ns/1ps

// Instruction memory with one cycle of read latency
// Loaded from outside through a Wishbone classic write-only slave
module instr_bram (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       arvalid,
  input  logic [fetch_pkg::xlen-1:0] araddr,
  output logic [31:0]                rdata,
  input  logic                       wb_cyc,
  input  logic                       wb_stb,
  input  logic                       wb_we,
  input  logic [fetch_pkg::xlen-1:0] wb_adr,
  input  logic [31:0]                wb_dat_w,
  output logic                       wb_ack
);

  logic [31:0]                          mem [fetch_pkg::imem_words];
  logic [fetch_pkg::imem_addr_bits-3:0] rd_idx;
  logic [fetch_pkg::imem_addr_bits-3:0] wr_idx;
  logic                                 wb_req;

  // The low two bits of each byte address are dropped
  assign rd_idx = araddr[fetch_pkg::imem_addr_bits-1:2];
  assign wr_idx = wb_adr[fetch_pkg::imem_addr_bits-1:2];

  // A new request is one not already being acknowledged
  assign wb_req = wb_cyc && wb_stb && !wb_ack;

  // Read port holds its last word while arvalid is low
  always_ff @(posedge clk) begin
    if (arvalid) begin
      rdata <= mem[rd_idx];
    end
  end

  // The word is written on the same edge that raises ack
  // Requests with we low are acknowledged and do nothing
  always_ff @(posedge clk) begin
    if (wb_req && wb_we) begin
      mem[wr_idx] <= wb_dat_w;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= wb_req;
    end
  end

endmodule

//--- pc_gen.sv
`timescale 1ns/1ps

// Program counter and next fetch address selection
// next_pc is combinational and addresses the memory in the same cycle
module pc_gen (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       stall,
  input  logic                       redirect_valid,
  input  logic [fetch_pkg::xlen-1:0] redirect_pc,
  pred_if.sink                       pred,
  output logic [fetch_pkg::xlen-1:0] pc,
  output logic [fetch_pkg::xlen-1:0] next_pc
);

  fetch_pkg::pc_src_e         pc_src;
  logic [fetch_pkg::xlen-1:0] seq_step;
  logic                       primed;

  // The first cycle after reset refetches the reset PC
  // Memory output is only aligned with pc from the second cycle on
  assign seq_step = (stall || !primed) ? 32'd0 : 32'd4;

  // Priority is redirect, then return, then taken hit, then sequential
  // Predictions are ignored while holding, so the held PC stays put
  always_comb begin
    if (redirect_valid) begin
      pc_src = fetch_pkg::src_redirect;
    end else if (stall || !primed) begin
      pc_src = fetch_pkg::src_seq;
    end else if (pred.hit && pred.is_return && pred.ras_valid) begin
      pc_src = fetch_pkg::src_ret;
    end else if (pred.hit && pred.taken) begin
      pc_src = fetch_pkg::src_pred;
    end else begin
      pc_src = fetch_pkg::src_seq;
    end
  end

  always_comb begin
    case (pc_src)
      fetch_pkg::src_redirect: next_pc = redirect_pc;
      fetch_pkg::src_ret:      next_pc = pred.ras_target;
      fetch_pkg::src_pred:     next_pc = pred.target;
      default:                 next_pc = pc + seq_step;
    endcase
  end

  // A redirect moves the PC even when the consumer is stalled
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc     <= fetch_pkg::reset_pc;
      primed <= 1'b0;
    end else if (!stall || redirect_valid) begin
      pc     <= next_pc;
      primed <= 1'b1;
    end
  end

endmodule

//--- return_stack.sv
`timescale 1ns/1ps

// Circular return address stack
// On overflow the pointer wraps and the oldest entry is overwritten
module return_stack (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       push,
  input  logic                       pop,
  input  logic [fetch_pkg::xlen-1:0] push_addr,
  pred_if.source                     pred
);

  logic [fetch_pkg::xlen-1:0]         stack_mem [fetch_pkg::ras_depth];
  logic [fetch_pkg::ras_ptr_bits-1:0] top_ptr;
  logic [fetch_pkg::ras_ptr_bits-1:0] push_ptr;
  logic [fetch_pkg::ras_ptr_bits:0]   count;

  // Slot that a push writes, wrapping past the last entry
  assign push_ptr = top_ptr + 1'b1;

  // Pointer and occupancy
  // The count saturates at the depth so wrapped pushes stay valid
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      top_ptr <= '0;
      count   <= '0;
    end else if (push) begin
      top_ptr <= push_ptr;
      if (count != fetch_pkg::ras_depth) begin
        count <= count + 1'b1;
      end
    end else if (pop && (count != '0)) begin
      top_ptr <= top_ptr - 1'b1;
      count   <= count - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      stack_mem[push_ptr] <= push_addr;
    end
  end

  // The top entry is only meaningful while something is stacked
  assign pred.ras_valid  = (count != '0);
  assign pred.ras_target = stack_mem[top_ptr];

endmodule

//--- branch_target_buffer.sv
`timescale 1ns/1ps

// Direct-mapped branch target buffer
// The lookup is registered, so an address presented as the next fetch
// address gives its prediction in the cycle where it is the current PC
module branch_target_buffer (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [fetch_pkg::xlen-1:0] lookup_pc,
  input  logic                       accept,
  input  logic                       upd_valid,
  input  logic [fetch_pkg::xlen-1:0] upd_pc,
  input  logic [fetch_pkg::xlen-1:0] upd_target,
  input  fetch_pkg::btb_kind_e       upd_kind,
  pred_if.source                     pred,
  output logic                       push,
  output logic                       pop
);

  logic [fetch_pkg::btb_entries-1:0]    entry_valid;
  logic [fetch_pkg::btb_tag_bits-1:0]   entry_tag    [fetch_pkg::btb_entries];
  logic [fetch_pkg::xlen-1:0]           entry_target [fetch_pkg::btb_entries];
  fetch_pkg::btb_kind_e                 entry_kind   [fetch_pkg::btb_entries];

  logic [fetch_pkg::btb_index_bits-1:0] lookup_idx;
  logic [fetch_pkg::btb_index_bits-1:0] upd_idx;

  logic                                 hit_q;
  fetch_pkg::btb_kind_e                 kind_q;
  logic [fetch_pkg::xlen-1:0]           target_q;

  // Word-address bits pick the entry and the upper bits form the tag
  assign lookup_idx = lookup_pc[fetch_pkg::btb_tag_lsb-1:2];
  assign upd_idx    = upd_pc[fetch_pkg::btb_tag_lsb-1:2];

  // An entry becomes valid when it is trained
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      entry_valid <= '0;
    end else if (upd_valid) begin
      entry_valid[upd_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (upd_valid) begin
      entry_tag[upd_idx]    <= upd_pc[fetch_pkg::xlen-1:fetch_pkg::btb_tag_lsb];
      entry_target[upd_idx] <= upd_target;
      entry_kind[upd_idx]   <= upd_kind;
    end
  end

  // A write in the same cycle as a lookup is seen one cycle later
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      hit_q  <= 1'b0;
      kind_q <= fetch_pkg::btb_branch;
    end else begin
      hit_q  <= entry_valid[lookup_idx] &&
                (entry_tag[lookup_idx] == lookup_pc[fetch_pkg::xlen-1:fetch_pkg::btb_tag_lsb]);
      kind_q <= entry_kind[lookup_idx];
    end
  end

  always_ff @(posedge clk) begin
    target_q <= entry_target[lookup_idx];
  end

  // Branches and calls are always predicted taken
  // A return takes its target from the stack instead
  assign pred.hit       = hit_q;
  assign pred.taken     = hit_q && (kind_q != fetch_pkg::btb_return);
  assign pred.target    = target_q;
  assign pred.is_return = hit_q && (kind_q == fetch_pkg::btb_return);

  // Stack updates only when the predicted fetch really moves on
  assign push = accept && hit_q && (kind_q == fetch_pkg::btb_call);
  assign pop  = accept && hit_q && (kind_q == fetch_pkg::btb_return);

endmodule

//--- pred_if.sv
`timescale 1ns/1ps

// One branch prediction for the current fetch PC
// The buffer fields and the stack fields come from two different blocks
// and are merged at the top level into a single bundle
interface pred_if;

  logic                       hit;
  logic                       taken;
  logic [fetch_pkg::xlen-1:0] target;
  logic                       is_return;

  // Top of the return address stack
  logic                       ras_valid;
  logic [fetch_pkg::xlen-1:0] ras_target;

  // Predictor side
  modport source(output hit, output taken, output target, output is_return,
                 output ras_valid, output ras_target);

  // Consumer side used by the PC generator and the fetch stage
  modport sink(input hit, input taken, input target, input is_return,
               input ras_valid, input ras_target);

endinterface

//--- fetch_pkg.sv
package fetch_pkg;

  // Address and instruction width of the fetch path
  localparam int xlen = 32;

  // First fetch address after reset
  localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;

  // Canonical NOP, addi x0,x0,0, placed in flushed slots
  localparam logic [31:0] i_nop = 32'h0000_0013;

  // Instruction memory geometry
  // Only the low byte-address bits select a word, the rest are ignored
  localparam int imem_words = 256;
  localparam int imem_addr_bits = 10;

  // Branch target buffer geometry
  // The index sits just above the two byte-offset bits of the PC
  localparam int btb_entries = 16;
  localparam int btb_index_bits = $clog2(btb_entries);
  localparam int btb_tag_lsb = btb_index_bits + 2;
  localparam int btb_tag_bits = xlen - btb_tag_lsb;

  // Return address stack geometry
  localparam int ras_depth = 4;
  localparam int ras_ptr_bits = $clog2(ras_depth);

  // Kind of control transfer recorded in a buffer entry
  typedef enum logic [1:0] {
    btb_branch = 2'd0,
    btb_call   = 2'd1,
    btb_return = 2'd2
  } btb_kind_e;

  // Source chosen for the next fetch address
  typedef enum logic [1:0] {
    src_seq      = 2'd0,
    src_pred     = 2'd1,
    src_ret      = 2'd2,
    src_redirect = 2'd3
  } pc_src_e;

endpackage
